// ==== hdl/reflet_mem_consts.svh ====
// reflet instruction memory constants
// address and data widths, memory map, init table length
// and the boot ROM loader program words
`ifndef REFLET_MEM_CONSTS_SVH
`define REFLET_MEM_CONSTS_SVH

`define REFLET_ADDR_W      15          // word address width
`define REFLET_DATA_W      16          // memory word width
`define REFLET_RAM_WORDS   32256       // ram covers words 0 to 0x7DFF
`define REFLET_BOOT_BASE   15'h7E00    // first boot rom word
`define REFLET_BOOT_WORDS  16          // populated rom words
`define REFLET_INIT_LEN    16          // init table entries
`define REFLET_AXI_ADDR_W  16          // bus byte address width

// loader program, word 0 first
`define REFLET_BOOT_W0     16'h1000
`define REFLET_BOOT_W1     16'h2E10
`define REFLET_BOOT_W2     16'h1F01
`define REFLET_BOOT_W3     16'h3C42
`define REFLET_BOOT_W4     16'h4A20
`define REFLET_BOOT_W5     16'h5B13
`define REFLET_BOOT_W6     16'h6071
`define REFLET_BOOT_W7     16'h7D08
`define REFLET_BOOT_W8     16'h8E35
`define REFLET_BOOT_W9     16'h9101
`define REFLET_BOOT_W10    16'hA2F0
`define REFLET_BOOT_W11    16'hB344
`define REFLET_BOOT_W12    16'hC0E7
`define REFLET_BOOT_W13    16'hD55A
`define REFLET_BOOT_W14    16'hE608
`define REFLET_BOOT_W15    16'hF00F

`endif

// ==== hdl/reflet_mem_pkg.sv ====
// reflet instruction memory types
// one memory access as seen by the ram and rom side,
// and the state encoding of the bus front end
`include "reflet_mem_consts.svh"

package reflet_mem_pkg;

    // single memory access, 32 bits in all
    typedef struct packed
    {
        logic [`REFLET_ADDR_W-1:0] addr;   // word address
        logic [`REFLET_DATA_W-1:0] wdata;  // write word
        logic                      we;     // 1 write, 0 read
    } mem_req_t;

    // bus port fsm
    // one transaction in flight at most
    typedef enum logic [1:0]
    {
        st_idle  = 2'd0,  // waiting for aw+w or ar
        st_wresp = 2'd1,  // bvalid up until bready
        st_rwait = 2'd2,  // read issued to memory
        st_rhold = 2'd3   // capture, then rvalid until rready
    } port_state_t;

endpackage

// ==== hdl/reflet_ram16.sv ====
// reflet instruction ram
// single port, 16-bit words, synchronous read
// accesses outside the first `words` words are dropped
// and read back as zero so the rom can be ORed in
`timescale 1ns/1ps
`include "reflet_mem_consts.svh"

module reflet_ram16 #(
    parameter int words     = `REFLET_RAM_WORDS,
    parameter bit resetable = 1'b1
    )(
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      enable,
    input  logic [`REFLET_ADDR_W-1:0] addr,
    input  logic [`REFLET_DATA_W-1:0] wdata,
    input  logic                      we,
    output logic [`REFLET_DATA_W-1:0] rdata
    );

    logic [`REFLET_DATA_W-1:0] mem [0:words-1];
    logic in_range;

    assign in_range = (32'(addr) < words); // inside the ram window

    // power up with an empty program
    initial
    begin
        for (int i = 0; i < words; i++)
            mem[i] = '0;
    end

    // write port
    always_ff @(posedge clk)
    begin
        if (enable && we && in_range)
            mem[addr] <= wdata;
    end

    // registered read, zero outside range
    always_ff @(posedge clk)
    begin
        if (resetable && !reset)
            rdata <= '0;             // optional output clear
        else if (enable)
        begin
            if (in_range)
                rdata <= mem[addr];  // read before write on same word
            else
                rdata <= '0;
        end
    end

endmodule

// ==== hdl/reflet_boot_rom16.sv ====
// reflet boot rom
// fixed loader program at the top of the word space,
// registered output, zero outside its own window
`timescale 1ns/1ps
`include "reflet_mem_consts.svh"

module reflet_boot_rom16 (
    input  logic                      clk,
    input  logic                      enable,
    input  logic [`REFLET_ADDR_W-1:0] addr,
    output logic [`REFLET_DATA_W-1:0] rdata
    );

    logic [`REFLET_ADDR_W-1:0] offset;   // word index inside the window
    logic                      populated;
    logic [`REFLET_DATA_W-1:0] rom_word;

    assign offset    = addr - `REFLET_BOOT_BASE;
    assign populated = (addr >= `REFLET_BOOT_BASE) && (offset < `REFLET_BOOT_WORDS);

    // program table
    always_comb
    begin
        case (offset[3:0])
            4'h0: rom_word = `REFLET_BOOT_W0;
            4'h1: rom_word = `REFLET_BOOT_W1;
            4'h2: rom_word = `REFLET_BOOT_W2;
            4'h3: rom_word = `REFLET_BOOT_W3;
            4'h4: rom_word = `REFLET_BOOT_W4;
            4'h5: rom_word = `REFLET_BOOT_W5;
            4'h6: rom_word = `REFLET_BOOT_W6;
            4'h7: rom_word = `REFLET_BOOT_W7;
            4'h8: rom_word = `REFLET_BOOT_W8;
            4'h9: rom_word = `REFLET_BOOT_W9;
            4'hA: rom_word = `REFLET_BOOT_W10;
            4'hB: rom_word = `REFLET_BOOT_W11;
            4'hC: rom_word = `REFLET_BOOT_W12;
            4'hD: rom_word = `REFLET_BOOT_W13;
            4'hE: rom_word = `REFLET_BOOT_W14;
            default: rom_word = `REFLET_BOOT_W15;
        endcase
    end

    // below the base or past the loader reads zero
    always_ff @(posedge clk)
    begin
        if (enable)
            rdata <= populated ? rom_word : '0;
    end

endmodule

// ==== hdl/reflet_inst16.sv ====
// reflet instruction memory
// ram plus boot rom behind one request port
// after reset a small sequencer writes a jump table into
// words 0 to 15 so the cpu lands in the boot rom
`timescale 1ns/1ps
`include "reflet_mem_consts.svh"

module reflet_inst16 #(
    parameter bit resetable = 1'b1
    )(
    input  logic                      clk,
    input  logic                      reset,
    input  reflet_mem_pkg::mem_req_t  req,
    input  logic                      req_valid,
    output logic [`REFLET_DATA_W-1:0] rdata,
    output logic                      inst_ready
    );

    import reflet_mem_pkg::*;

    logic [3:0]                init_cnt;   // table entry being written
    logic                      init_done;  // last entry written
    logic [7:0]                init_byte;
    mem_req_t                  init_req;
    mem_req_t                  sel_req;    // request seen by the memories
    logic                      sel_en;
    logic [`REFLET_DATA_W-1:0] ram_rdata;
    logic [`REFLET_DATA_W-1:0] rom_rdata;

    // init sequencer, ready one cycle after the last write
    always_ff @(posedge clk)
    begin
        if (!reset)
        begin
            init_cnt   <= '0;
            init_done  <= 1'b0;
            inst_ready <= 1'b0;
        end
        else
        begin
            if (!init_done)
            begin
                if (init_cnt == 4'(`REFLET_INIT_LEN - 1))
                    init_done <= 1'b1;
                else
                    init_cnt <= init_cnt + 4'd1;
            end
            inst_ready <= init_done;
        end
    end

    // byte table, pointer to boot rom then jump stub
    always_comb
    begin
        case (init_cnt)
            4'h1:    init_byte = 8'h7E;  // boot rom word address high byte
            4'h4:    init_byte = 8'h10;  // set 0
            4'h5:    init_byte = 8'hF0;  // load wr
            4'h6:    init_byte = 8'h08;  // jmp
            default: init_byte = 8'h00;
        endcase
    end

    assign init_req.addr  = `REFLET_ADDR_W'(init_cnt);
    assign init_req.wdata = {8'h00, init_byte};
    assign init_req.we    = !init_done;  // idle gap before ready

    // sequencer owns the memory until ready
    assign sel_req = inst_ready ? req : init_req;
    assign sel_en  = inst_ready ? req_valid : 1'b1;

    reflet_ram16 #(.words(`REFLET_RAM_WORDS), .resetable(resetable)) ram (
        .clk    (clk),
        .reset  (reset),
        .enable (sel_en),
        .addr   (sel_req.addr),
        .wdata  (sel_req.wdata),
        .we     (sel_req.we),
        .rdata  (ram_rdata));

    reflet_boot_rom16 boot_rom (
        .clk    (clk),
        .enable (sel_en),
        .addr   (sel_req.addr),
        .rdata  (rom_rdata));

    assign rdata = ram_rdata | rom_rdata; // disjoint windows, each zero outside

endmodule

// ==== hdl/reflet_axil_mem_port.sv ====
// reflet axi4-lite memory port
// slave front end, one write or read in flight,
// writes win over reads, nothing served before inst_ready
// responses are always OKAY
`timescale 1ns/1ps
`include "reflet_mem_consts.svh"

module reflet_axil_mem_port (
    input  logic                          clk,
    input  logic                          reset,
    // write address
    input  logic [`REFLET_AXI_ADDR_W-1:0] awaddr,
    input  logic                          awvalid,
    output logic                          awready,
    // write data
    input  logic [31:0]                   wdata,
    input  logic [3:0]                    wstrb,   // ignored, full word writes
    input  logic                          wvalid,
    output logic                          wready,
    // write response
    output logic [1:0]                    bresp,
    output logic                          bvalid,
    input  logic                          bready,
    // read address
    input  logic [`REFLET_AXI_ADDR_W-1:0] araddr,
    input  logic                          arvalid,
    output logic                          arready,
    // read data
    output logic [31:0]                   rdata_o,
    output logic [1:0]                    rresp,
    output logic                          rvalid,
    input  logic                          rready,
    // memory side
    output reflet_mem_pkg::mem_req_t      mem_req,
    output logic                          mem_valid,
    input  logic [`REFLET_DATA_W-1:0]     mem_rdata,
    input  logic                          inst_ready
    );

    import reflet_mem_pkg::*;

    port_state_t               state;
    logic                      can_accept;
    logic                      write_go;   // aw and w taken this cycle
    logic                      read_go;    // ar taken this cycle
    logic [`REFLET_ADDR_W-1:0] rd_addr;    // latched read word address
    logic [`REFLET_DATA_W-1:0] rd_data;    // held read word

    assign can_accept = (state == st_idle) && inst_ready;
    assign write_go   = can_accept && awvalid && wvalid;
    assign read_go    = can_accept && arvalid && !(awvalid && wvalid);

    assign awready = write_go; // both channels in the same cycle
    assign wready  = write_go;
    assign arready = read_go;

    // write goes straight through, read one cycle after ar
    always_comb
    begin
        mem_req   = '0;
        mem_valid = 1'b0;
        if (write_go)
        begin
            mem_req.addr  = awaddr[`REFLET_AXI_ADDR_W-1:1];
            mem_req.wdata = wdata[`REFLET_DATA_W-1:0];
            mem_req.we    = 1'b1;
            mem_valid     = 1'b1;
        end
        else if (state == st_rwait)
        begin
            mem_req.addr = rd_addr;
            mem_valid    = 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!reset)
        begin
            state  <= st_idle;
            rvalid <= 1'b0;
        end
        else
        begin
            case (state)
                st_idle:
                begin
                    if (write_go)
                        state <= st_wresp;
                    else if (read_go)
                        state <= st_rwait;
                end
                st_wresp:
                begin
                    if (bready)
                        state <= st_idle;
                end
                st_rwait:
                    state <= st_rhold;   // memory samples the address here
                st_rhold:
                begin
                    if (!rvalid)
                        rvalid <= 1'b1;  // word captured this edge
                    else if (rready)
                    begin
                        rvalid <= 1'b0;
                        state  <= st_idle;
                    end
                end
                default:
                    state <= st_idle;
            endcase
        end
    end

    // payload registers
    always_ff @(posedge clk)
    begin
        if (read_go)
            rd_addr <= araddr[`REFLET_AXI_ADDR_W-1:1];
        if (state == st_rhold && !rvalid)
            rd_data <= mem_rdata;        // stable while rvalid waits
    end

    assign bvalid  = (state == st_wresp);
    assign bresp   = 2'b00;              // okay, rom writes too
    assign rresp   = 2'b00;
    assign rdata_o = {16'h0000, rd_data};

endmodule

// ==== hdl/reflet_inst_sys.sv ====
// reflet instruction memory system
// axi4-lite slave port joined to the instruction memory
`timescale 1ns/1ps
`include "reflet_mem_consts.svh"

module reflet_inst_sys (
    input  logic                          clk,
    input  logic                          reset,
    input  logic [`REFLET_AXI_ADDR_W-1:0] awaddr,
    input  logic                          awvalid,
    output logic                          awready,
    input  logic [31:0]                   wdata,
    input  logic [3:0]                    wstrb,
    input  logic                          wvalid,
    output logic                          wready,
    output logic [1:0]                    bresp,
    output logic                          bvalid,
    input  logic                          bready,
    input  logic [`REFLET_AXI_ADDR_W-1:0] araddr,
    input  logic                          arvalid,
    output logic                          arready,
    output logic [31:0]                   rdata,
    output logic [1:0]                    rresp,
    output logic                          rvalid,
    input  logic                          rready,
    output logic                          inst_ready
    );

    import reflet_mem_pkg::*;

    mem_req_t                  mem_req;     // port to memory
    logic                      mem_valid;
    logic [`REFLET_DATA_W-1:0] mem_rdata;   // ram | rom, one cycle later

    reflet_axil_mem_port port (
        .clk        (clk),
        .reset      (reset),
        .awaddr     (awaddr),
        .awvalid    (awvalid),
        .awready    (awready),
        .wdata      (wdata),
        .wstrb      (wstrb),
        .wvalid     (wvalid),
        .wready     (wready),
        .bresp      (bresp),
        .bvalid     (bvalid),
        .bready     (bready),
        .araddr     (araddr),
        .arvalid    (arvalid),
        .arready    (arready),
        .rdata_o    (rdata),
        .rresp      (rresp),
        .rvalid     (rvalid),
        .rready     (rready),
        .mem_req    (mem_req),
        .mem_valid  (mem_valid),
        .mem_rdata  (mem_rdata),
        .inst_ready (inst_ready));

    reflet_inst16 inst_mem (
        .clk        (clk),
        .reset      (reset),
        .req        (mem_req),
        .req_valid  (mem_valid),
        .rdata      (mem_rdata),
        .inst_ready (inst_ready));

endmodule

// ==== test/tb_reflet_inst_sys.sv ====
// testbench for the reflet instruction memory system
// table of axi4-lite writes and reads checked against fixed values,
// plus lfsr driven random traffic checked against a shadow of the ram
`timescale 1ns/1ps
`include "reflet_mem_consts.svh"

module tb_reflet_inst_sys;

    typedef enum logic [2:0] {op_wr, op_rd, op_wr_stall, op_rd_stall, op_rand} op_t;

    typedef struct
    {
        op_t         op;
        logic [14:0] addr;      // word address
        logic [31:0] data;
        logic [31:0] expected;  // rdata, or bresp for writes
        string       name;
    } row_t;

    localparam logic [31:0] lfsr_taps = 32'h8020_0003;
    localparam int stall_cycles = 4;  // ready held low this long
    localparam int random_rows  = 40;

    logic        clk;
    logic        reset;
    logic [15:0] awaddr;
    logic        awvalid;
    logic        awready;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic        wvalid;
    logic        wready;
    logic [1:0]  bresp;
    logic        bvalid;
    logic        bready;
    logic [15:0] araddr;
    logic        arvalid;
    logic        arready;
    logic [31:0] rdata;
    logic [1:0]  rresp;
    logic        rvalid;
    logic        rready;
    logic        inst_ready;

    row_t        rows [$];
    logic [15:0] shadow [0:`REFLET_RAM_WORDS-1];  // expected ram contents
    logic [7:0]  init_table [0:15] = '{8'h00, 8'h7E, 8'h00, 8'h00, 8'h10, 8'hF0, 8'h08, 8'h00,
                                       8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00};
    logic [15:0] boot_words [0:15] = '{`REFLET_BOOT_W0, `REFLET_BOOT_W1, `REFLET_BOOT_W2,
                                       `REFLET_BOOT_W3, `REFLET_BOOT_W4, `REFLET_BOOT_W5,
                                       `REFLET_BOOT_W6, `REFLET_BOOT_W7, `REFLET_BOOT_W8,
                                       `REFLET_BOOT_W9, `REFLET_BOOT_W10, `REFLET_BOOT_W11,
                                       `REFLET_BOOT_W12, `REFLET_BOOT_W13, `REFLET_BOOT_W14,
                                       `REFLET_BOOT_W15};
    logic [31:0] lfsr = 32'hfb3e_25e8;
    int          cycles      = 0;
    int          cycle_limit = 100;  // raised once the table is built
    int          errors      = 0;

    reflet_inst_sys reflet_inst_sys_i (.*);

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // run limit
    always @(posedge clk)
    begin
        cycles++;
        if (cycles > cycle_limit)
        begin
            $display("Timeout: the DUT gave no response within %0d cycles", cycle_limit);
            $display("Some tests failed");
            $fatal(1, "cycle limit reached");
        end
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected)
        begin
            errors++;
            $display("Fail %s: expected %h, actual %h", name, expected, actual);
            $display("Some tests failed");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    // galois lfsr, one step per bit taken
    function automatic logic [31:0] lfsr_bits(input int n);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < n; i++)
        begin
            value = {value[30:0], lfsr[0]};
            lfsr  = (lfsr >> 1) ^ (lfsr[0] ? lfsr_taps : 32'h0);
        end
        return value;
    endfunction

    // a stalled write offers a repeat of itself while bvalid waits
    task automatic axi_write(input string name, input logic [15:0] addr, input logic [31:0] data,
                             input int stall, input bit offered, output logic [1:0] resp);
        int passes;
        passes = (stall > 0) ? 2 : 1;
        resp   = 2'b00;
        if (!offered)
        begin
            awaddr  = addr;
            wdata   = data;
            wstrb   = 4'hF;
            awvalid = 1'b1;
            wvalid  = 1'b1;
        end
        for (int n = 0; n < passes; n++)
        begin
            if (n > 0 || !offered)
            begin
                do
                begin
                    @(negedge clk);
                end while (!(awready && wready));
            end
            @(posedge clk);  // aw and w handshake
            #1;
            awvalid = (n + 1 < passes);
            wvalid  = (n + 1 < passes);
            bready  = (stall == 0 || n > 0);
            @(negedge clk);
            check_value({name, " bvalid next cycle"}, 1, 32'(bvalid));
            resp = resp | bresp;
            if (n == 0)
            begin
                repeat (stall)
                begin
                    @(posedge clk);
                    @(negedge clk);
                    check_value({name, " bvalid held"}, 1, 32'(bvalid));
                    check_value({name, " aw blocked"}, 0, 32'(awready));
                end
            end
            if (!bready)
            begin
                @(posedge clk);
                #1 bready = 1'b1;
            end
            @(posedge clk);  // b handshake
            #1 bready = 1'b0;
        end
        if (32'(addr[15:1]) < `REFLET_RAM_WORDS)
            shadow[addr[15:1]] = data[15:0];  // rom window keeps no state
    endtask

    // a stalled read offers a repeat of itself while rvalid waits
    task automatic axi_read(input string name, input logic [15:0] addr, input int stall,
                            output logic [31:0] data);
        int          passes;
        int          lat;
        logic [31:0] word;
        passes  = (stall > 0) ? 2 : 1;
        araddr  = addr;
        arvalid = 1'b1;
        for (int n = 0; n < passes; n++)
        begin
            do
            begin
                @(negedge clk);
            end while (!arready);
            @(posedge clk);  // ar handshake
            #1;
            arvalid = (n + 1 < passes);
            rready  = (stall == 0 || n > 0);
            lat     = 0;
            @(negedge clk);
            while (!rvalid)
            begin
                @(posedge clk);
                lat++;
                @(negedge clk);
            end
            check_value({name, " rvalid latency"}, 2, lat);
            check_value({name, " rresp okay"}, 0, 32'(rresp));
            word = rdata;
            if (n == 0)
                data = word;
            else
                check_value({name, " repeated read"}, data, word);
            if (n == 0)
            begin
                repeat (stall)
                begin
                    @(posedge clk);
                    @(negedge clk);
                    check_value({name, " rvalid held"}, 1, 32'(rvalid));
                    check_value({name, " rdata held"}, word, rdata);
                    check_value({name, " ar blocked"}, 0, 32'(arready));
                end
            end
            if (!rready)
            begin
                @(posedge clk);
                #1 rready = 1'b1;
            end
            @(posedge clk);  // r handshake
            #1 rready = 1'b0;
        end
    endtask

    task automatic add_row(input op_t op, input logic [14:0] addr, input logic [31:0] data,
                           input logic [31:0] expected, input string name);
        row_t r;
        r.op       = op;
        r.addr     = addr;
        r.data     = data;
        r.expected = expected;
        r.name     = name;
        rows.push_back(r);
    endtask

    task automatic build_table();
        for (int n = 0; n < 16; n++)
            add_row(op_rd, 15'(n), 0, {24'h0, init_table[n]}, $sformatf("init word %0d", n));
        add_row(op_wr, 15'h0000, 32'hABCD_1234, 0, "overwrite init word 0");
        add_row(op_rd, 15'h0000, 0, 32'h0000_1234, "read back word 0");  // upper half dropped
        add_row(op_wr, 15'h0006, 32'h0000_5A5A, 0, "overwrite init word 6");
        add_row(op_rd, 15'h0006, 0, 32'h0000_5A5A, "read back word 6");
        add_row(op_wr, 15'h7DFF, 32'hFFFF_BEEF, 0, "write last ram word");
        add_row(op_rd, 15'h7DFF, 0, 32'h0000_BEEF, "read last ram word");
        for (int n = 0; n < 16; n++)
            add_row(op_rd, `REFLET_BOOT_BASE + 15'(n), 0, {16'h0, boot_words[n]},
                    $sformatf("boot rom word %0d", n));
        add_row(op_rd, 15'h7E10, 0, 0, "rom past loader");
        add_row(op_wr, 15'h7E03, 32'h0000_FFFF, 0, "rom write okay");
        add_row(op_rd, 15'h7E03, 0, {16'h0, boot_words[3]}, "rom word 3 unchanged");
        add_row(op_wr_stall, 15'h0100, 32'h0000_1111, 0, "stalled write");
        add_row(op_rd_stall, 15'h0100, 0, 32'h0000_1111, "stalled read");
        for (int n = 0; n < random_rows; n++)
            add_row(op_rand, 0, 0, 0, $sformatf("random %0d", n));
    endtask

    initial
    begin
        logic [31:0] rd;
        logic [1:0]  resp;
        logic [14:0] addr;
        logic [15:0] wd;
        int          edges;
        reset   = 1'b0;
        awaddr  = '0;
        awvalid = 1'b0;
        wdata   = '0;
        wstrb   = 4'h0;
        wvalid  = 1'b0;
        bready  = 1'b0;
        araddr  = '0;
        arvalid = 1'b0;
        rready  = 1'b0;
        build_table();
        cycle_limit = 20 * rows.size() + 100;
        for (int a = 0; a < `REFLET_RAM_WORDS; a++)
            shadow[a] = (a < 16) ? {8'h00, init_table[a]} : 16'h0000;

        repeat (3) @(posedge clk);
        #1 reset = 1'b1;
        // offer a write and a read while the init sequencer runs
        awaddr  = 16'h0040;
        wdata   = 32'h5555_0A0A;
        wstrb   = 4'hF;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        araddr  = 16'h0002;
        arvalid = 1'b1;
        edges   = 0;
        do
        begin
            @(posedge clk);
            edges++;
            @(negedge clk);
            if (!inst_ready)
            begin
                check_value("no awready before ready", 0, 32'(awready));
                check_value("no wready before ready", 0, 32'(wready));
                check_value("no arready before ready", 0, 32'(arready));
                check_value("no response before ready", 0, 32'({bvalid, rvalid}));
            end
        end while (!inst_ready);
        check_value("inst_ready delay", `REFLET_INIT_LEN + 1, edges);
        check_value("write wins over read", 32'h2, 32'({awready, arready}));
        axi_write("startup write", 16'h0040, 32'h5555_0A0A, 0, 1'b1, resp);
        check_value("startup write", 0, 32'(resp));
        axi_read("startup read", 16'h0002, 0, rd);
        check_value("startup read", {24'h0, init_table[1]}, rd);

        foreach (rows[i])
        begin
            case (rows[i].op)
                op_wr, op_wr_stall:
                begin
                    axi_write(rows[i].name, {rows[i].addr, 1'b0}, rows[i].data,
                              (rows[i].op == op_wr_stall) ? stall_cycles : 0, 1'b0, resp);
                    check_value(rows[i].name, rows[i].expected, 32'(resp));
                end
                op_rd, op_rd_stall:
                begin
                    axi_read(rows[i].name, {rows[i].addr, 1'b0},
                             (rows[i].op == op_rd_stall) ? stall_cycles : 0, rd);
                    check_value(rows[i].name, rows[i].expected, rd);
                end
                default:
                begin
                    addr = 15'(lfsr_bits(6));  // words 0 to 63, init words included
                    if (lfsr_bits(1) == 32'h1)
                    begin
                        wd = 16'(lfsr_bits(16));
                        axi_write(rows[i].name, {addr, 1'b0}, {16'h0, wd}, 0, 1'b0, resp);
                        check_value(rows[i].name, 0, 32'(resp));
                    end
                    else
                    begin
                        axi_read(rows[i].name, {addr, 1'b0}, 0, rd);
                        check_value(rows[i].name, {16'h0, shadow[addr]}, rd);
                    end
                end
            endcase
        end

        if (errors == 0)
        begin
            $display("All tests passed");
        end
        else
        begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// ==== list.f ====
+incdir+hdl
hdl/reflet_mem_pkg.sv
hdl/reflet_ram16.sv
hdl/reflet_boot_rom16.sv
hdl/reflet_inst16.sv
hdl/reflet_axil_mem_port.sv
hdl/reflet_inst_sys.sv
test/tb_reflet_inst_sys.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing -Wno-fatal
TOP       = tb_reflet_inst_sys
FILELIST  = list.f
BUILD     = obj_dir
SIM       = $(BUILD)/V$(TOP)
LOG       = sim.log
SOURCES   = $(shell grep -v '^+' $(FILELIST)) hdl/reflet_mem_consts.svh

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD) -o V$(TOP)

run: $(SIM)
	-./$(SIM) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "All tests passed" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
